// ==== vic_core.f ====
+incdir+dv
source/vic_pkg.sv
source/vic_timing_if.sv
source/phase_clock.sv
source/raster_counter.sv
source/vic_registers.sv
source/sprite_dma_slot.sv
source/bus_arbiter.sv
source/vic_core.sv
dv/tb_vic_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f vic_core.f --top-module tb_vic_core -o sim_vic_core

# the simulation may stop with an error status, the log decides
./obj_dir/sim_vic_core > sim.log 2>&1 || true
cat sim.log

if grep -q "PASS: all tests" sim.log; then
   exit 0
else
   echo "simulation did not pass, see sim.log"
   exit 1
fi

// ==== dv/vic_tb_tasks.svh ====
// wait loops, each sampling on the falling edge with its own limit
task automatic wait_phi(input logic v, input int limit);
   int n;
   n = 0;
   do begin
      @(negedge clk_dot4x);
      n++;
      if (n > limit)
         report_failure("timeout waiting for the phi clock level");
   end while (clk_phi_o !== v);
endtask

task automatic wait_line(input raster_line_t l, input int limit);
   int n;
   for (n = 0; raster_line_o !== l; n++) begin
      if (n > limit)
         report_failure($sformatf("timeout waiting for raster line %0d", l));
      @(negedge clk_dot4x);
   end
endtask

task automatic wait_x(input raster_x_t x, input int limit);
   int n;
   for (n = 0; raster_x_o !== x; n++) begin
      if (n > limit)
         report_failure($sformatf("timeout waiting for raster x %0d", x));
      @(negedge clk_dot4x);
   end
endtask

task automatic wait_ba(input logic v, input int limit);
   int n;
   for (n = 0; ba_o !== v; n++) begin
      if (n > limit)
         report_failure("timeout waiting for a change of ba");
      @(negedge clk_dot4x);
   end
endtask

// write lands on the last clock of phi high
task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
   wait_phi(1'b1, 64);
   ce_i  = 1'b0;
   rw_i  = 1'b0;
   adi_i = addr;
   dbi_i = data;
   wait_phi(1'b0, 64);
   ce_i = 1'b1;
   rw_i = 1'b1;
endtask

// reads are combinational, sampled well before the next rising edge
task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
   @(negedge clk_dot4x);
   adi_i = addr;
   ce_i  = 1'b0;
   rw_i  = 1'b1;
   #10;
   data = dbo_o;
   @(negedge clk_dot4x);
   ce_i = 1'b1;
endtask

// reports whether ba went low anywhere on line l
task automatic scan_line(input raster_line_t l, output logic saw_low);
   int n;
   saw_low = 1'b0;
   wait_line(l, 800000);
   for (n = 0; raster_line_o === l; n++) begin
      if (n > 3000)
         report_failure($sformatf("raster line %0d never ended", l));
      if (!ba_o)
         saw_low = 1'b1;
      @(negedge clk_dot4x);
   end
endtask

task automatic test_timing(input chip_e chip);
   int        cnt;
   raster_x_t x1;
   raster_line_t l1;
   chip_i = chip;
   apply_reset();
   // phi period, 16 low and 16 high
   wait_phi(1'b1, 64);
   cnt = 1;
   while (clk_phi_o !== 1'b0 && cnt < 64) begin
      @(negedge clk_dot4x);
      cnt++;
   end
   check_x(raster_x_t'(cnt - 1), 10'd16, "phi high length");
   while (clk_phi_o !== 1'b1 && cnt < 64) begin
      @(negedge clk_dot4x);
      cnt++;
   end
   check_x(raster_x_t'(cnt - 1), 10'd32, "phi period");
   // x steps every 4 clocks
   x1 = raster_x_o;
   wait_x(x1 + 10'd1, 8);
   x1 = raster_x_o;
   for (int k = 1; k <= 8; k++) begin
      repeat (4) @(negedge clk_dot4x);
      check_x(raster_x_o, x1 + raster_x_t'(k), "dot step");
   end
   // line end
   wait_x(last_dot(chip), 3000);
   l1 = raster_line_o;
   repeat (4) @(negedge clk_dot4x);
   check_x(raster_x_o, 10'd0, "x wrap");
   check_line(raster_line_o, l1 + 9'd1, "line step on x wrap");
   // frame end
   wait_line(last_line(chip), 800000);
   while (raster_line_o === last_line(chip) && cnt < 4000) begin
      @(negedge clk_dot4x);
      cnt++;
   end
   check_line(raster_line_o, 9'd0, "frame wrap");
   check_x(raster_x_o, 10'd0, "x at frame wrap");
endtask

task automatic test_registers();
   reg_data_t    val;
   reg_data_t    rd;
   raster_line_t probe_line;
   logic         prev_phi;
   for (int n = 0; n < 8; n++) begin
      rng = xorshift32(rng);
      val = rng[7:0];
      bus_write(REG_SPR_Y0 + reg_addr_t'(2 * n), val);
      bus_read(REG_SPR_Y0 + reg_addr_t'(2 * n), rd);
      check_data(rd, val, $sformatf("sprite %0d y readback", n));
   end
   // raster register read on a known line
   rng        = xorshift32(rng);
   probe_line = raster_line_t'(1 + rng % 250);
   wait_line(probe_line, 800000);
   bus_read(REG_RASTER, rd);
   check_data(rd, probe_line[7:0], "raster read");
   bus_read(6'd40, rd);
   check_data(rd, 8'hff, "unmapped read");
   // unmapped address, so random writes change nothing
   // ba stays high here so aec is phi one clock late
   adi_i    = 6'd40;
   prev_phi = clk_phi_o;
   for (int k = 0; k < 96; k++) begin
      @(negedge clk_dot4x);
      rng  = xorshift32(rng);
      ce_i = rng[0];
      rw_i = rng[1];
      #10;
      check_bit(aec_o, prev_phi, "aec follows phi");
      check_bit(vic_write_db_o, prev_phi & rw_i & !ce_i, "data bus write enable");
      prev_phi = clk_phi_o;
   end
   ce_i = 1'b1;
   rw_i = 1'b1;
endtask

task automatic test_raster_irq();
   raster_line_t target;
   reg_data_t    rd;
   int           n;
   rng    = xorshift32(rng);
   target = raster_line_t'(20 + rng % 200);
   wait_line(target - 9'd5, 800000);
   bus_write(REG_RASTER, target[7:0]);
   bus_write(REG_CTRL1, {target[8], 7'd0});
   bus_write(REG_IRQ, 8'h01);
   bus_write(REG_IRQ_EN, 8'h01);
   wait_line(target, 20000);
   for (n = 0; irq_o !== 1'b1; n++) begin
      if (n > 200)
         report_failure("irq did not rise on the compare line");
      @(negedge clk_dot4x);
   end
   bus_read(REG_IRQ, rd);
   check_data(rd, 8'hff, "irq status with enable");
   bus_write(REG_IRQ, 8'h01);
   // no second hit on the same line
   while (raster_line_o === target) begin
      check_bit(irq_o, 1'b0, "irq after clear");
      @(negedge clk_dot4x);
   end
   // enable off, latch still sets
   bus_write(REG_IRQ_EN, 8'h00);
   bus_write(REG_RASTER, target[7:0] + 8'd10);
   wait_line(target + 9'd10, 30000);
   rd = 8'h00;
   for (n = 0; rd[0] !== 1'b1; n++) begin
      if (n > 100)
         report_failure("irq latch did not set with enable off");
      bus_read(REG_IRQ, rd);
   end
   check_data(rd, 8'h7f, "irq status without enable");
   check_bit(irq_o, 1'b0, "irq output with enable off");
   bus_write(REG_IRQ, 8'h01);
endtask

task automatic test_badlines();
   logic [2:0] ys;
   logic       low;
   chip_i = CHIP_6569;
   apply_reset();
   rng = xorshift32(rng);
   ys  = rng[2:0];
   bus_write(REG_CTRL1, {5'b00010, ys});
   for (int l = 48; l < 112; l++) begin
      scan_line(raster_line_t'(l), low);
      check_bit(low, l[2:0] == ys, $sformatf("ba low on line %0d", l));
   end
endtask

task automatic test_aec_cascade();
   int   phases;
   logic phase_aec;
   int   n;
   int   tries;
   // use a fall at a line start since the window at the line end is too short
   tries = 0;
   do begin
      tries++;
      if (tries > 16)
         report_failure("ba never fell at the start of a line");
      wait_ba(1'b1, 40000);
      wait_ba(1'b0, 40000);
   end while (raster_x_o !== 10'd0);
   phases    = 0;
   phase_aec = 1'b0;
   // count phi-high phases with aec high until ba returns
   for (n = 0; ba_o !== 1'b1; n++) begin
      if (n > 10000)
         report_failure("ba stayed low too long");
      if (clk_phi_o) begin
         if (aec_o)
            phase_aec = 1'b1;
      end else if (phase_aec) begin
         phases++;
         phase_aec = 1'b0;
      end
      @(negedge clk_dot4x);
   end
   if (phase_aec)
      phases++;
   check_x(raster_x_t'(phases), 10'd3, "phi-high phases with aec after ba fell");
endtask

task automatic test_sprite_dma();
   int        n;
   sprite_y_t y;
   int        rem;
   int        first;
   int        last;
   logic      low;
   chip_i = CHIP_6569;
   apply_reset();
   rng = xorshift32(rng);
   n   = rng % 8;
   rng = xorshift32(rng);
   // kept above 55 so the low byte does not match again past line 255
   y   = sprite_y_t'(56 + rng % 144);
   bus_write(REG_SPR_Y0 + reg_addr_t'(2 * n), y);
   bus_write(REG_SPR_EN, reg_data_t'(1 << n));
   // the window may start or spill past the line end
   rem   = int'(last_dot(chip_i)) + 1 - int'(dma_check_dot(chip_i));
   first = (16 * n < rem) ? int'(y) : int'(y) + 1;
   last  = (16 * n + 40 > rem) ? int'(y) + 21 : int'(y) + 20;
   for (int l = 1; l <= int'(last_line(chip_i)); l++) begin
      scan_line(raster_line_t'(l), low);
      check_bit(low, l >= first && l <= last,
                $sformatf("sprite %0d y %0d ba on line %0d", n, y, l));
   end
endtask

// ==== dv/tb_vic_core.sv ====
`timescale 1ns/1ns

module tb_vic_core;
   import vic_pkg::*;

   logic         clk_dot4x;
   logic         rst;
   chip_e        chip_i;
   logic         ce_i;
   logic         rw_i;
   reg_addr_t    adi_i;
   reg_data_t    dbi_i;
   logic         clk_phi_o;
   raster_x_t    raster_x_o;
   raster_line_t raster_line_o;
   reg_data_t    dbo_o;
   logic         irq_o;
   logic         ba_o;
   logic         aec_o;
   logic         vic_write_db_o;

   // random state
   logic [31:0]  rng;
   int           err_count;

   vic_core #(.NUM_SPRITES(8)) u_vic_core (
      .clk_dot4x(clk_dot4x), .rst(rst), .chip_i(chip_i),
      .ce_i(ce_i), .rw_i(rw_i), .adi_i(adi_i), .dbi_i(dbi_i),
      .clk_phi_o(clk_phi_o), .raster_x_o(raster_x_o), .raster_line_o(raster_line_o),
      .dbo_o(dbo_o), .irq_o(irq_o), .ba_o(ba_o), .aec_o(aec_o),
      .vic_write_db_o(vic_write_db_o)
   );

   // 100 ns dot4x period
   always #50 clk_dot4x = ~clk_dot4x;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // chip limits as given by the data sheets
   function automatic raster_x_t last_dot(input chip_e chip);
      if (chip == CHIP_6567R8)
         return 10'd519;
      if (chip == CHIP_6567R56A)
         return 10'd511;
      return 10'd503;
   endfunction

   function automatic raster_line_t last_line(input chip_e chip);
      if (chip == CHIP_6567R8)
         return 9'd262;
      if (chip == CHIP_6567R56A)
         return 9'd261;
      return 9'd311;
   endfunction

   function automatic raster_x_t dma_check_dot(input chip_e chip);
      if (chip == CHIP_6567R8 || chip == CHIP_6567R56A)
         return 10'd440;
      return 10'd432;
   endfunction

   task automatic report_failure(input string what);
      err_count++;
      $display("%s", what);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_line(input raster_line_t got, input raster_line_t exp, input string msg);
      if (got !== exp)
         report_failure($sformatf("FAIL @%0t: %s, line %0d expected %0d", $time, msg, got, exp));
   endtask

   task automatic check_x(input raster_x_t got, input raster_x_t exp, input string msg);
      if (got !== exp)
         report_failure($sformatf("FAIL @%0t: %s, x %0d expected %0d", $time, msg, got, exp));
   endtask

   task automatic check_data(input reg_data_t got, input reg_data_t exp, input string msg);
      if (got !== exp)
         report_failure($sformatf("FAIL @%0t: %s, data %02h expected %02h", $time, msg, got, exp));
   endtask

   task automatic check_bit(input logic got, input logic exp, input string msg);
      if (got !== exp)
         report_failure($sformatf("FAIL @%0t: %s, bit %b expected %b", $time, msg, got, exp));
   endtask

   // reset held for 4 clocks, released on a falling edge
   task automatic apply_reset();
      @(negedge clk_dot4x);
      rst = 1'b1;
      repeat (4) @(negedge clk_dot4x);
      rst = 1'b0;
   endtask

   `include "vic_tb_tasks.svh"

   initial begin
      clk_dot4x = 1'b0;
      rst       = 1'b1;
      chip_i    = CHIP_6569;
      ce_i      = 1'b1;
      rw_i      = 1'b1;
      adi_i     = '0;
      dbi_i     = '0;
      rng       = 32'hae66_5ef7;
      err_count = 0;

      test_timing(CHIP_6567R8);
      test_timing(CHIP_6567R56A);
      test_timing(CHIP_6569);
      test_registers();
      test_raster_irq();
      test_badlines();
      test_aec_cascade();
      test_sprite_dma();

      if (err_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// ==== source/vic_core.sv ====
`timescale 1ns/1ns

module vic_core #(
   parameter int NUM_SPRITES = 8
) (
   input  logic                 clk_dot4x,
   input  logic                 rst,
   input  vic_pkg::chip_e       chip_i,
   input  logic                 ce_i,
   input  logic                 rw_i,
   input  vic_pkg::reg_addr_t   adi_i,
   input  vic_pkg::reg_data_t   dbi_i,
   output logic                 clk_phi_o,
   output vic_pkg::raster_x_t   raster_x_o,
   output vic_pkg::raster_line_t raster_line_o,
   output vic_pkg::reg_data_t   dbo_o,
   output logic                 irq_o,
   output logic                 ba_o,
   output logic                 aec_o,
   output logic                 vic_write_db_o
);
   import vic_pkg::*;

   // the slot generate below covers at most 8 sprites
   if (NUM_SPRITES < 1 || NUM_SPRITES > 8) begin : g_bad_sprites
      $error("NUM_SPRITES must be between 1 and 8");
   end

   vic_timing_if tim ();

   logic                   den;
   logic [2:0]             yscroll;
   logic [NUM_SPRITES-1:0] spr_en;
   sprite_y_t              spr_y [NUM_SPRITES];
   logic [NUM_SPRITES-1:0] ba_req;

   phase_clock u_phase_clock (.clk_dot4x(clk_dot4x), .rst(rst), .tim(tim.src_phase));

   raster_counter u_raster_counter (
      .clk_dot4x(clk_dot4x), .rst(rst), .chip_i(chip_i), .tim(tim.src_raster)
   );

   vic_registers #(.NUM_SPRITES(NUM_SPRITES)) u_vic_registers (
      .clk_dot4x(clk_dot4x), .rst(rst), .tim(tim.sink),
      .ce_i(ce_i), .rw_i(rw_i), .adi_i(adi_i), .dbi_i(dbi_i),
      .dbo_o(dbo_o), .irq_o(irq_o), .den_o(den), .yscroll_o(yscroll),
      .spr_en_o(spr_en), .spr_y_o(spr_y)
   );

   // one dma tracker per sprite
   for (genvar n = 0; n < NUM_SPRITES; n++) begin : g_slot
      sprite_dma_slot #(.SLOT(n)) u_slot (
         .clk_dot4x(clk_dot4x), .rst(rst), .tim(tim.sink), .chip_i(chip_i),
         .en_i(spr_en[n]), .y_i(spr_y[n]), .ba_req_o(ba_req[n])
      );
   end

   bus_arbiter #(.NUM_SPRITES(NUM_SPRITES)) u_bus_arbiter (
      .clk_dot4x(clk_dot4x), .rst(rst), .tim(tim.sink), .chip_i(chip_i),
      .den_i(den), .yscroll_i(yscroll), .ba_req_i(ba_req),
      .ce_i(ce_i), .rw_i(rw_i),
      .ba_o(ba_o), .aec_o(aec_o), .vic_write_db_o(vic_write_db_o)
   );

   assign clk_phi_o     = tim.phi;
   assign raster_x_o    = tim.raster_x;
   assign raster_line_o = tim.raster_line;

endmodule

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ns

module bus_arbiter #(
   parameter int NUM_SPRITES = 8
) (
   input  logic                   clk_dot4x,
   input  logic                   rst,
   vic_timing_if.sink             tim,
   input  vic_pkg::chip_e         chip_i,
   input  logic                   den_i,
   input  logic [2:0]             yscroll_i,
   input  logic [NUM_SPRITES-1:0] ba_req_i,
   input  logic                   ce_i,
   input  logic                   rw_i,
   output logic                   ba_o,
   output logic                   aec_o,
   output logic                   vic_write_db_o
);
   import vic_pkg::*;

   logic allow_bad_lines;
   logic badline;
   // chars fetch needs the bus
   logic ba_chars_low;
   // ba history over the last three phi-high ends
   logic ba1;
   logic ba2;
   logic ba3;

   // den is sampled on line 48 only, window closes on line 248
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         allow_bad_lines <= 1'b0;
      end else if (tim.phi && tim.phase_start[0]) begin
         if (tim.raster_line == BADLINE_FIRST && den_i)
            allow_bad_lines <= 1'b1;
         if (tim.raster_line == BADLINE_LAST)
            allow_bad_lines <= 1'b0;
      end
   end

   assign badline = allow_bad_lines
                    && (tim.raster_line >= BADLINE_FIRST)
                    && (tim.raster_line < BADLINE_LAST)
                    && (tim.raster_line[2:0] == yscroll_i);

   // window wraps through x = 0
   assign ba_chars_low = badline && ((tim.raster_x >= chars_ba_start(chip_i))
                                     || (tim.raster_x < CHARS_BA_END));

   // any request pulls ba low
   assign ba_o = !(ba_chars_low || (|ba_req_i));

   // shift ba through three stages on the last clock of phi high
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ba1 <= 1'b1;
         ba2 <= 1'b1;
         ba3 <= 1'b1;
      end else if (tim.phi && tim.phase_start[15]) begin
         ba1 <= ba_o;
         ba2 <= ba1 | ba_o;
         ba3 <= ba2 | ba_o;
      end
   end

   // aec follows phi, cpu keeps phi high for three more phases after ba falls
   always_ff @(posedge clk_dot4x) begin
      if (rst)
         aec_o <= 1'b0;
      else
         aec_o <= ba_o ? tim.phi : (ba3 & tim.phi);
   end

   // cpu reading us
   assign vic_write_db_o = aec_o && rw_i && !ce_i;

endmodule

// ==== source/sprite_dma_slot.sv ====
`timescale 1ns/1ns

module sprite_dma_slot #(
   parameter int SLOT = 0
) (
   input  logic              clk_dot4x,
   input  logic              rst,
   vic_timing_if.sink        tim,
   input  vic_pkg::chip_e    chip_i,
   input  logic              en_i,
   input  vic_pkg::sprite_y_t y_i,
   output logic              ba_req_o
);
   import vic_pkg::*;

   // this slot's ba window, relative to the dma check dot
   localparam raster_x_t WIN_START = raster_x_t'(SLOT) * SPRITE_BA_STEP;
   localparam raster_x_t WIN_END   = WIN_START + SPRITE_BA_SPAN;

   logic       active;
   sprite_mc_t mc;
   raster_x_t  dma_x;
   // x measured from the dma check dot, wrapped at the line end
   raster_x_t  dx_off;
   // last clock before x reaches the check dot
   logic       chk_tick;

   always_comb begin
      dma_x = sprite_dma_x(chip_i);
      if (tim.raster_x >= dma_x)
         dx_off = tim.raster_x - dma_x;
      else
         dx_off = tim.raster_x + line_max_x(chip_i) + 10'd1 - dma_x;
   end

   // state changes take effect right as x becomes the check dot
   assign chk_tick = tim.dot_tick && (tim.raster_x == dma_x - 10'd1);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         active <= 1'b0;
      end else if (chk_tick) begin
         if (!active) begin
            // start on the line matching y
            if (en_i && y_i == tim.raster_line[7:0])
               active <= 1'b1;
         end else if (mc + 6'd3 == SPRITE_LINES_MC) begin
            // 21 lines fetched
            active <= 1'b0;
         end
      end
   end

   // line counter, cleared on activation
   always_ff @(posedge clk_dot4x) begin
      if (chk_tick) begin
         if (!active)
            mc <= '0;
         else
            mc <= mc + 6'd3;
      end
   end

   assign ba_req_o = active && (dx_off >= WIN_START) && (dx_off < WIN_END);

endmodule

// ==== source/vic_registers.sv ====
`timescale 1ns/1ns

module vic_registers #(
   parameter int NUM_SPRITES = 8
) (
   input  logic                 clk_dot4x,
   input  logic                 rst,
   vic_timing_if.sink           tim,
   input  logic                 ce_i,
   input  logic                 rw_i,
   input  vic_pkg::reg_addr_t   adi_i,
   input  vic_pkg::reg_data_t   dbi_i,
   output vic_pkg::reg_data_t   dbo_o,
   output logic                 irq_o,
   output logic                 den_o,
   output logic [2:0]           yscroll_o,
   output logic [NUM_SPRITES-1:0] spr_en_o,
   output vic_pkg::sprite_y_t   spr_y_o [NUM_SPRITES]
);
   import vic_pkg::*;

   // sprite y values
   sprite_y_t    spr_y [NUM_SPRITES];
   // $d011 without bit 7, that one goes to the compare
   logic [6:0]   ctrl1;
   raster_line_t raster_cmp;
   logic [NUM_SPRITES-1:0] spr_en;
   // raster irq enable, bit 0 of $d01a
   logic         erst;
   // raster irq latch
   logic         irst;
   // set once the latch fired on the current line
   logic         irq_fired;
   logic         wr_en;

   // cpu write lands on the last clock of phi high
   assign wr_en = !ce_i && !rw_i && tim.phi && tim.phase_start[15];

   // control registers and the irq latch
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ctrl1      <= '0;
         raster_cmp <= '0;
         spr_en     <= '0;
         erst       <= 1'b0;
         irst       <= 1'b0;
         irq_fired  <= 1'b0;
      end else begin
         // compare at the start of phi high, once per line
         if (tim.phi && tim.phase_start[0]) begin
            if (tim.raster_line == raster_cmp) begin
               if (!irq_fired) begin
                  irq_fired <= 1'b1;
                  irst      <= 1'b1;
               end
            end else begin
               irq_fired <= 1'b0;
            end
         end
         if (wr_en) begin
            case (adi_i)
               REG_CTRL1: begin
                  ctrl1         <= dbi_i[6:0];
                  raster_cmp[8] <= dbi_i[7];
               end
               REG_RASTER: raster_cmp[7:0] <= dbi_i;
               REG_SPR_EN: spr_en <= dbi_i[NUM_SPRITES-1:0];
               // writing a 1 acknowledges
               REG_IRQ:    if (dbi_i[0]) irst <= 1'b0;
               REG_IRQ_EN: erst <= dbi_i[0];
               default:    ;
            endcase
         end
      end
   end

   // sprite y bank, 1 + 2n
   always_ff @(posedge clk_dot4x) begin
      if (wr_en) begin
         for (int n = 0; n < NUM_SPRITES; n++) begin
            if (adi_i == reg_addr_t'(REG_SPR_Y0 + 2 * n))
               spr_y[n] <= dbi_i;
         end
      end
   end

   assign irq_o = irst & erst;

   // read mux, unmapped bits and addresses read as ones
   always_comb begin
      dbo_o = 8'hff;
      for (int n = 0; n < NUM_SPRITES; n++) begin
         if (adi_i == reg_addr_t'(REG_SPR_Y0 + 2 * n))
            dbo_o = spr_y[n];
      end
      case (adi_i)
         REG_CTRL1:  dbo_o = {tim.raster_line[8], ctrl1};
         REG_RASTER: dbo_o = tim.raster_line[7:0];
         REG_SPR_EN: dbo_o[NUM_SPRITES-1:0] = spr_en;
         REG_IRQ:    dbo_o = {irq_o, 6'h3f, irst};
         REG_IRQ_EN: dbo_o = {7'h7f, erst};
         default:    ;
      endcase
   end

   assign den_o     = ctrl1[4];
   assign yscroll_o = ctrl1[2:0];
   assign spr_en_o  = spr_en;
   assign spr_y_o   = spr_y;

   // write strobe and compare decode expect exactly one half-phase bit
   a_phase_onehot : assert property (
      @(posedge clk_dot4x) disable iff (rst)
      $onehot(tim.phase_start)
   );

endmodule

// ==== source/raster_counter.sv ====
`timescale 1ns/1ns

module raster_counter (
   input  logic             clk_dot4x,
   input  logic             rst,
   input  vic_pkg::chip_e   chip_i,
   vic_timing_if.src_raster tim
);
   import vic_pkg::*;

   raster_x_t    raster_x;
   raster_line_t raster_line;
   // wrap points for the selected chip
   raster_x_t    x_max;
   raster_line_t line_max;

   assign x_max    = line_max_x(chip_i);
   assign line_max = frame_max_line(chip_i);

   // x steps once per dot, line steps on x wrap
   // compares use >= so a chip change mid-line still wraps
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_x    <= '0;
         raster_line <= '0;
      end else if (tim.dot_tick) begin
         if (raster_x >= x_max) begin
            raster_x <= '0;
            // end of line
            if (raster_line >= line_max)
               raster_line <= '0;
            else
               raster_line <= raster_line + 9'd1;
         end else begin
            raster_x <= raster_x + 10'd1;
         end
      end
   end

   assign tim.raster_x    = raster_x;
   assign tim.raster_line = raster_line;

   // after any dot step the position is inside the line of the chip in use then
   a_x_in_line : assert property (
      @(posedge clk_dot4x) disable iff (rst)
      tim.dot_tick |=> (tim.raster_x <= line_max_x($past(chip_i)))
   );

endmodule

// ==== source/phase_clock.sv ====
`timescale 1ns/1ns

module phase_clock (
   input  logic            clk_dot4x,
   input  logic            rst,
   vic_timing_if.src_phase tim
);

   // phi ring, bit 31 is phi
   // after reset phi sits 16 clocks low, then 16 high
   logic [31:0] phi_ring;
   // one-hot half-phase position
   logic [15:0] phase_ring;
   // dot tick ring
   logic [3:0]  dot_ring;

   // all rings rotate left once per dot4x clock
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phi_ring   <= 32'h0000_ffff;
         phase_ring <= 16'h0001;
         dot_ring   <= 4'b0001;
      end else begin
         phi_ring   <= {phi_ring[30:0], phi_ring[31]};
         phase_ring <= {phase_ring[14:0], phase_ring[15]};
         dot_ring   <= {dot_ring[2:0], dot_ring[3]};
      end
   end

   assign tim.phi         = phi_ring[31];
   assign tim.phase_start = phase_ring;
   // bit 0 repeats every 4 clocks
   assign tim.dot_tick    = dot_ring[0];

   // phi and the half-phase ring are separate rings and must stay aligned
   a_phi_on_phase_start : assert property (
      @(posedge clk_dot4x) disable iff (rst)
      (tim.phi != $past(tim.phi)) |-> tim.phase_start[0]
   );

endmodule

// ==== source/vic_timing_if.sv ====
`timescale 1ns/1ns

interface vic_timing_if;
   import vic_pkg::*;

   // phi clock, low for the vic half and high for the cpu half
   logic         phi;
   // one-hot position in the half-phase
   // bit 0 is the first clock, bit 15 the last before phi flips
   logic [15:0]  phase_start;
   // one clock in four, the dot advances after it
   logic         dot_tick;
   raster_x_t    raster_x;
   raster_line_t raster_line;

   modport src_phase (output phi, output phase_start, output dot_tick);

   // raster side only steps on the dot tick
   modport src_raster (input dot_tick, output raster_x, output raster_line);

   modport sink (
      input phi,
      input phase_start,
      input dot_tick,
      input raster_x,
      input raster_line
   );

endinterface

// ==== source/vic_pkg.sv ====
package vic_pkg;

   // chip model select, the unused code acts as a 6569
   typedef enum logic [1:0] {
      CHIP_6567R8   = 2'd0,
      CHIP_6567R56A = 2'd1,
      CHIP_6569     = 2'd2,
      CHIP_UNUSED   = 2'd3
   } chip_e;

   // dot position in a line
   typedef logic [9:0] raster_x_t;
   typedef logic [8:0] raster_line_t;
   // raster_x / 8
   typedef logic [6:0] cycle_num_t;
   typedef logic [5:0] reg_addr_t;
   typedef logic [7:0] reg_data_t;
   typedef logic [7:0] sprite_y_t;
   // sprite line counter, steps by 3
   typedef logic [5:0] sprite_mc_t;

   // badline range, first is inclusive, last is exclusive
   localparam raster_line_t BADLINE_FIRST = 9'd48;
   localparam raster_line_t BADLINE_LAST  = 9'd248;

   // sprite ba windows, counted from the dma check dot
   localparam raster_x_t SPRITE_BA_SPAN = 10'd40;
   localparam raster_x_t SPRITE_BA_STEP = 10'd16;

   // chars fetch ba window wraps through the line end
   localparam raster_x_t CHARS_BA_START_6567 = 10'd500;
   localparam raster_x_t CHARS_BA_START_6569 = 10'd492;
   localparam raster_x_t CHARS_BA_END        = 10'd332;

   localparam sprite_mc_t SPRITE_LINES_MC = 6'd63;

   // register map
   localparam reg_addr_t REG_SPR_Y0 = 6'd1;
   localparam reg_addr_t REG_CTRL1  = 6'd17;
   localparam reg_addr_t REG_RASTER = 6'd18;
   localparam reg_addr_t REG_SPR_EN = 6'd21;
   localparam reg_addr_t REG_IRQ    = 6'd25;
   localparam reg_addr_t REG_IRQ_EN = 6'd26;

   // last dot of a line
   function automatic raster_x_t line_max_x(chip_e chip);
      case (chip)
         CHIP_6567R8:   return 10'd519;
         CHIP_6567R56A: return 10'd511;
         default:       return 10'd503;
      endcase
   endfunction

   // last line of a frame
   function automatic raster_line_t frame_max_line(chip_e chip);
      case (chip)
         CHIP_6567R8:   return 9'd262;
         CHIP_6567R56A: return 9'd261;
         default:       return 9'd311;
      endcase
   endfunction

   // dma check dot, cycle 55 on ntsc parts and 54 on pal
   function automatic raster_x_t sprite_dma_x(chip_e chip);
      cycle_num_t chk_cycle;
      if (chip == CHIP_6567R8 || chip == CHIP_6567R56A)
         chk_cycle = 7'd55;
      else
         chk_cycle = 7'd54;
      return {chk_cycle, 3'b000};
   endfunction

   function automatic raster_x_t chars_ba_start(chip_e chip);
      if (chip == CHIP_6567R8 || chip == CHIP_6567R56A)
         return CHARS_BA_START_6567;
      return CHARS_BA_START_6569;
   endfunction

endpackage
